// ==== design/retire_pkg.sv ====
package retire_pkg;

    // data and address width
    parameter int xlen = 32;

    // architectural register index width
    parameter int reg_idx_w = 5;

    // retirement status reported with each commit
    typedef enum logic [1:0] {
        no_error      = 2'd0,
        illegal_inst  = 2'd1,
        halted_on_wfi = 2'd2
    } exception_code_e;

    // kind of unit that produced a completion
    typedef enum logic [1:0] {
        alu    = 2'd0,
        load   = 2'd1,
        store  = 2'd2,
        branch = 2'd3
    } funit_e;

endpackage

// ==== design/rob_tracker.sv ====
`timescale 1ns/1ps

module rob_tracker #(
    parameter int rob_sz = 8
) (
    input  logic                      clock,
    input  logic                      arst_n,
    input  logic                      flush,
    input  logic                      disp_valid,
    output logic                      disp_ready,
    output logic [$clog2(rob_sz)-1:0] disp_tag,
    input  logic                      move_head,
    output logic [$clog2(rob_sz)-1:0] head_tag
);

    localparam int tag_w = $clog2(rob_sz);

    // pointers carry one wrap bit above the tag
    logic [tag_w:0] head;
    logic [tag_w:0] tail;
    logic [tag_w:0] occupancy;
    logic           disp_fire;

    // wrap bit makes plain subtraction give the fill level
    assign occupancy  = tail - head;
    assign disp_ready = occupancy != (tag_w + 1)'(rob_sz);
    assign disp_fire  = disp_valid && disp_ready;

    // tags are just the pointer bits below the wrap bit
    assign disp_tag = tail[tag_w-1:0];
    assign head_tag = head[tag_w-1:0];

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            head <= '0;
            tail <= '0;
        end else if (flush) begin
            // drop everything in flight
            // an instruction dispatched this cycle survives as the new oldest
            head <= tail;
            tail <= tail + (tag_w + 1)'(disp_fire);
        end else begin
            if (disp_fire) begin
                tail <= tail + 1'b1;
            end
            if (move_head) begin
                head <= head + 1'b1;
            end
        end
    end

    // retire must never commit from an empty window
    a_no_move_when_empty: assert property (
        @(posedge clock) disable iff (!arst_n)
        move_head |-> occupancy != '0
    );

endmodule

// ==== design/retire.sv ====
`timescale 1ns/1ps

module retire import retire_pkg::*; #(
    parameter int rob_sz = 8
) (
    input  logic                      clock,
    input  logic                      arst_n,
    input  logic                      flush,
    input  logic                      cmp_valid,
    input  logic [$clog2(rob_sz)-1:0] cmp_tag,
    input  funit_e                    cmp_kind,
    input  logic                      cmp_illegal,
    input  logic                      cmp_halt,
    input  logic                      cmp_rd_en,
    input  logic [reg_idx_w-1:0]      cmp_rd_idx,
    input  logic [xlen-1:0]           cmp_rd_data,
    input  logic [xlen-1:0]           cmp_npc,
    input  logic [xlen-1:0]           cmp_result,
    input  logic [xlen-1:0]           cmp_store_data,
    input  logic [$clog2(rob_sz)-1:0] head_tag,
    input  logic                      stq_free,
    output logic                      move_head,
    output logic                      store_push,
    output logic [xlen-1:0]           store_addr,
    output logic [xlen-1:0]           store_data,
    output logic                      commit_valid,
    output exception_code_e           commit_error,
    output logic                      commit_wr_en,
    output logic [reg_idx_w-1:0]      commit_wr_idx,
    output logic [xlen-1:0]           commit_wr_data,
    output logic [xlen-1:0]           commit_npc
);

    // per-tag completion buffer, one array per field
    logic [rob_sz-1:0]    buf_valid;
    funit_e               buf_kind [rob_sz];
    exception_code_e      buf_status [rob_sz];
    logic                 buf_rd_en [rob_sz];
    logic [reg_idx_w-1:0] buf_rd_idx [rob_sz];
    logic [xlen-1:0]      buf_rd_data [rob_sz];
    logic [xlen-1:0]      buf_npc [rob_sz];
    logic [xlen-1:0]      buf_result [rob_sz];
    logic [xlen-1:0]      buf_store_data [rob_sz];

    exception_code_e in_status;
    logic            cmp_take;
    logic            do_forward;
    logic            out_is_store;
    logic            commit;
    logic            buf_write;

    // illegal beats halt, halt beats none
    assign in_status = cmp_illegal ? illegal_inst :
                       cmp_halt    ? halted_on_wfi :
                       no_error;

    // completions during a flush are dropped
    assign cmp_take   = cmp_valid && !flush;
    assign do_forward = cmp_take && (cmp_tag == head_tag) && !buf_valid[head_tag];

    // outgoing entry: forwarded packet or buffered head
    assign out_is_store = do_forward ? (cmp_kind == store) : (buf_kind[head_tag] == store);

    // a store waits at the head until the queue has room
    assign commit = (do_forward || buf_valid[head_tag]) && !flush &&
                    !(out_is_store && !stq_free);

    assign move_head  = commit;
    assign store_push = commit && out_is_store;
    assign store_addr = do_forward ? cmp_result : buf_result[head_tag];
    assign store_data = do_forward ? cmp_store_data : buf_store_data[head_tag];

    // commit fields read zero outside a retirement
    always_comb begin
        commit_valid   = commit;
        commit_error   = no_error;
        commit_wr_en   = 1'b0;
        commit_wr_idx  = '0;
        commit_wr_data = '0;
        commit_npc     = '0;
        if (commit && do_forward) begin
            commit_error   = in_status;
            commit_wr_en   = cmp_rd_en;
            commit_wr_idx  = cmp_rd_idx;
            commit_wr_data = cmp_rd_data;
            commit_npc     = cmp_npc;
        end else if (commit) begin
            commit_error   = buf_status[head_tag];
            commit_wr_en   = buf_rd_en[head_tag];
            commit_wr_idx  = buf_rd_idx[head_tag];
            commit_wr_data = buf_rd_data[head_tag];
            commit_npc     = buf_npc[head_tag];
        end
    end

    // buffer unless it leaves right away
    // a blocked forward still lands in the slot and retries from there
    assign buf_write = cmp_take && !(do_forward && commit);

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            buf_valid <= '0;
        end else if (flush) begin
            buf_valid <= '0;
        end else begin
            if (buf_write) begin
                buf_valid[cmp_tag] <= 1'b1;
            end
            // free the head slot once it retires from the buffer
            if (commit && !do_forward) begin
                buf_valid[head_tag] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (buf_write) begin
            buf_kind[cmp_tag]       <= cmp_kind;
            buf_status[cmp_tag]     <= in_status;
            buf_rd_en[cmp_tag]      <= cmp_rd_en;
            buf_rd_idx[cmp_tag]     <= cmp_rd_idx;
            buf_rd_data[cmp_tag]    <= cmp_rd_data;
            buf_npc[cmp_tag]        <= cmp_npc;
            buf_result[cmp_tag]     <= cmp_result;
            buf_store_data[cmp_tag] <= cmp_store_data;
        end
    end

    // each tag completes once per trip through the window
    a_no_overwrite: assert property (
        @(posedge clock) disable iff (!arst_n)
        cmp_take |-> !buf_valid[cmp_tag]
    );

endmodule

// ==== design/store_issue.sv ====
`timescale 1ns/1ps

module store_issue import retire_pkg::*; #(
    parameter int stq_depth     = 4,
    parameter int store_credits = 2
) (
    input  logic            clock,
    input  logic            arst_n,
    input  logic            store_push,
    input  logic [xlen-1:0] store_addr,
    input  logic [xlen-1:0] store_data,
    output logic            stq_free,
    output logic            st_valid,
    output logic [xlen-1:0] st_addr,
    output logic [xlen-1:0] st_data,
    input  logic            st_credit
);

    localparam int ptr_w  = $clog2(stq_depth);
    localparam int cred_w = $clog2(store_credits + 1);

    // address and data pairs waiting for the cache
    logic [xlen-1:0] q_addr [stq_depth];
    logic [xlen-1:0] q_data [stq_depth];

    logic [ptr_w:0]  wr_ptr;
    logic [ptr_w:0]  rd_ptr;
    logic [ptr_w:0]  count;
    logic [cred_w-1:0] credit_cnt;
    logic            issue;

    assign count    = wr_ptr - rd_ptr;
    assign stq_free = count != (ptr_w + 1)'(stq_depth);

    // oldest store leaves once a credit is held
    assign issue = (count != '0) && (credit_cnt != '0);

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            st_valid   <= 1'b0;
            credit_cnt <= cred_w'(store_credits);
        end else begin
            if (store_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (issue) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            st_valid <= issue;
            // spend on issue, refill on each returned credit
            if (issue && !st_credit) begin
                credit_cnt <= credit_cnt - 1'b1;
            end else if (!issue && st_credit) begin
                credit_cnt <= credit_cnt + 1'b1;
            end
        end
    end

    // queue storage and cache payload
    always_ff @(posedge clock) begin
        if (store_push) begin
            q_addr[wr_ptr[ptr_w-1:0]] <= store_addr;
            q_data[wr_ptr[ptr_w-1:0]] <= store_data;
        end
        if (issue) begin
            st_addr <= q_addr[rd_ptr[ptr_w-1:0]];
            st_data <= q_data[rd_ptr[ptr_w-1:0]];
        end
    end

    // retire only pushes while a slot is open
    a_no_push_full: assert property (
        @(posedge clock) disable iff (!arst_n)
        store_push |-> count < (ptr_w + 1)'(stq_depth)
    );

    // cache never returns more than it was given
    a_credit_bound: assert property (
        @(posedge clock) disable iff (!arst_n)
        credit_cnt <= cred_w'(store_credits)
    );

endmodule

// ==== design/retire_sys.sv ====
`timescale 1ns/1ps

module retire_sys import retire_pkg::*; #(
    parameter int rob_sz        = 8,
    parameter int stq_depth     = 4,
    parameter int store_credits = 2
) (
    input  logic                      clock,
    input  logic                      arst_n,
    input  logic                      flush,
    // dispatch
    input  logic                      disp_valid,
    output logic                      disp_ready,
    output logic [$clog2(rob_sz)-1:0] disp_tag,
    // completion
    input  logic                      cmp_valid,
    input  logic [$clog2(rob_sz)-1:0] cmp_tag,
    input  funit_e                    cmp_kind,
    input  logic                      cmp_illegal,
    input  logic                      cmp_halt,
    input  logic                      cmp_rd_en,
    input  logic [reg_idx_w-1:0]      cmp_rd_idx,
    input  logic [xlen-1:0]           cmp_rd_data,
    input  logic [xlen-1:0]           cmp_npc,
    input  logic [xlen-1:0]           cmp_result,
    input  logic [xlen-1:0]           cmp_store_data,
    // commit
    output logic                      commit_valid,
    output exception_code_e           commit_error,
    output logic                      commit_wr_en,
    output logic [reg_idx_w-1:0]      commit_wr_idx,
    output logic [xlen-1:0]           commit_wr_data,
    output logic [xlen-1:0]           commit_npc,
    // data cache store port
    output logic                      st_valid,
    output logic [xlen-1:0]           st_addr,
    output logic [xlen-1:0]           st_data,
    input  logic                      st_credit
);

    logic [$clog2(rob_sz)-1:0] head_tag;
    logic                      move_head;
    logic                      store_push;
    logic [xlen-1:0]           store_addr;
    logic [xlen-1:0]           store_data;
    logic                      stq_free;

    rob_tracker #(.rob_sz(rob_sz)) tracker_i (
        .clock, .arst_n, .flush, .disp_valid, .disp_ready, .disp_tag,
        .move_head, .head_tag
    );

    retire #(.rob_sz(rob_sz)) retire_i (
        .clock, .arst_n, .flush,
        .cmp_valid, .cmp_tag, .cmp_kind, .cmp_illegal, .cmp_halt,
        .cmp_rd_en, .cmp_rd_idx, .cmp_rd_data, .cmp_npc, .cmp_result, .cmp_store_data,
        .head_tag, .stq_free, .move_head, .store_push, .store_addr, .store_data,
        .commit_valid, .commit_error, .commit_wr_en, .commit_wr_idx,
        .commit_wr_data, .commit_npc
    );

    // retired stores drain toward the cache
    store_issue #(.stq_depth(stq_depth), .store_credits(store_credits)) stq_i (
        .clock, .arst_n, .store_push, .store_addr, .store_data, .stq_free,
        .st_valid, .st_addr, .st_data, .st_credit
    );

endmodule

// ==== dv/retire_sys_tb.sv ====
`timescale 1ns/1ps

module retire_sys_tb import retire_pkg::*; ();

    localparam int rob_sz        = 8;
    localparam int store_credits = 2;
    localparam int tag_w         = $clog2(rob_sz);
    localparam int period        = 40;

    logic                 clock, arst_n, flush, st_credit;
    logic                 disp_valid, disp_ready;
    logic [tag_w-1:0]     disp_tag, cmp_tag;
    logic                 cmp_valid, cmp_illegal, cmp_halt, cmp_rd_en;
    funit_e               cmp_kind;
    logic [reg_idx_w-1:0] cmp_rd_idx, commit_wr_idx;
    logic [xlen-1:0]      cmp_rd_data, cmp_npc, cmp_result, cmp_store_data;
    logic                 commit_valid, commit_wr_en, st_valid;
    exception_code_e      commit_error;
    logic [xlen-1:0]      commit_wr_data, commit_npc, st_addr, st_data;

    // reference model: tags in program order, per-tag completions, pending stores
    logic [tag_w-1:0]     prog_q[$];
    logic [2*xlen-1:0]    st_q[$];
    logic                 done [rob_sz];
    logic                 r_store [rob_sz];
    exception_code_e      r_err [rob_sz];
    logic                 r_wen [rob_sz];
    logic [reg_idx_w-1:0] r_widx [rob_sz];
    logic [xlen-1:0]      r_wdata [rob_sz], r_npc [rob_sz], r_addr [rob_sz], r_sdata [rob_sz];
    logic [tag_w-1:0]     next_tag = '0;
    int                   pulses = 0;
    int                   returned = 0;
    int                   n_lines = 0;

    retire_sys dut_i (.*);

    initial begin
        clock = 1'b0;
        forever #(period / 2) clock = ~clock;
    end

    task automatic fail_now(input string msg);
        $display("FAIL %0t: %s", $time, msg);
        $display(">>> FAIL");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "run aborted");
    endtask

    // illegal wins over halt
    function automatic exception_code_e status_of(input logic ill, input logic halt);
        if (ill) return illegal_inst;
        if (halt) return halted_on_wfi;
        return no_error;
    endfunction

    task automatic check_commit(input exception_code_e err, input logic wen,
                                input logic [reg_idx_w-1:0] widx,
                                input logic [xlen-1:0] wdata, input logic [xlen-1:0] npc);
        if (commit_error !== err || commit_wr_en !== wen || commit_wr_idx !== widx ||
            commit_wr_data !== wdata || commit_npc !== npc)
            fail_now($sformatf("commit %s %b x%0d=%h npc %h, expected %s %b x%0d=%h npc %h",
                commit_error.name(), commit_wr_en, commit_wr_idx, commit_wr_data,
                commit_npc, err.name(), wen, widx, wdata, npc));
    endtask

    task automatic check_store(input logic [xlen-1:0] addr, input logic [xlen-1:0] data);
        if (st_addr !== addr || st_data !== data)
            fail_now($sformatf("store %h <- %h, expected %h <- %h", st_addr, st_data, addr, data));
    endtask

    task automatic clear_inputs();
        disp_valid <= 1'b0;
        cmp_valid  <= 1'b0;
        flush      <= 1'b0;
        st_credit  <= 1'b0;
    endtask

    // sampled mid-cycle, after the driving edge has settled
    task automatic step_model();
        logic [tag_w-1:0] head;
        if (disp_ready !== (prog_q.size() < rob_sz))
            fail_now("disp_ready does not follow ROB occupancy");
        if (disp_valid && disp_ready && disp_tag !== next_tag)
            fail_now($sformatf("disp_tag %0d, expected %0d", disp_tag, next_tag));
        if (cmp_valid && !flush) begin
            done[cmp_tag]    = 1'b1;
            r_store[cmp_tag] = cmp_kind == store;
            r_err[cmp_tag]   = status_of(cmp_illegal, cmp_halt);
            r_wen[cmp_tag]   = cmp_rd_en;
            r_widx[cmp_tag]  = cmp_rd_idx;
            r_wdata[cmp_tag] = cmp_rd_data;
            r_npc[cmp_tag]   = cmp_npc;
            r_addr[cmp_tag]  = cmp_result;
            r_sdata[cmp_tag] = cmp_store_data;
        end
        if (commit_valid) begin
            if (flush || prog_q.size() == 0 || !done[prog_q[0]])
                fail_now("commit_valid without a completed oldest instruction");
            head = prog_q.pop_front();
            check_commit(r_err[head], r_wen[head], r_widx[head], r_wdata[head], r_npc[head]);
            if (r_store[head]) st_q.push_back({r_addr[head], r_sdata[head]});
            done[head] = 1'b0;
        end else begin
            check_commit(no_error, 1'b0, '0, '0, '0);
            // only a store may wait at the head
            if (!flush && prog_q.size() != 0 && done[prog_q[0]] && !r_store[prog_q[0]])
                fail_now("completed oldest instruction did not commit");
        end
        if (flush) begin
            foreach (done[i]) done[i] = 1'b0;
            prog_q.delete();
        end
        if (disp_valid && disp_ready) begin
            prog_q.push_back(next_tag);
            next_tag++;
        end
        if (st_valid) begin
            if (st_q.size() == 0) fail_now("st_valid with no retired store pending");
            pulses++;
            if (pulses > store_credits + returned) fail_now("st_valid without a credit held");
            check_store(st_q[0][2*xlen-1:xlen], st_q[0][xlen-1:0]);
            void'(st_q.pop_front());
        end
        if (st_credit) returned++;
    endtask

    initial begin
        int fd, n, code, tag, kind, ill, halt, wen;
        string op, line;
        logic [reg_idx_w-1:0] widx;
        logic [xlen-1:0] wdata, npc, res, sdata;
        logic [tag_w-1:0] pool[$];
        {arst_n, disp_valid, cmp_valid, flush, st_credit} = '0;
        {cmp_tag, cmp_illegal, cmp_halt, cmp_rd_en, cmp_rd_idx} = '0;
        {cmp_rd_data, cmp_npc, cmp_result, cmp_store_data} = '0;
        cmp_kind = alu;
        foreach (done[i]) done[i] = 1'b0;
        void'($urandom(32'h2ae6_34e6));
        // line count sets the watchdog limit
        fd = $fopen("dv/retire_sys_testdata.txt", "r");
        if (fd == 0) abort_run("cannot open dv/retire_sys_testdata.txt");
        while ($fgets(line, fd)) n_lines++;
        $fclose(fd);
        fd = $fopen("dv/retire_sys_testdata.txt", "r");
        repeat (8) @(posedge clock);
        arst_n <= 1'b1;
        while ($fscanf(fd, "%s", op) == 1) begin
            n = 1;
            if (op[0] == "#") begin
                void'($fgets(line, fd));
                continue;
            end
            if (op == "complete") begin
                code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h", tag, kind, ill, halt, wen,
                               widx, wdata, npc, res, sdata);
                if (code != 10) abort_run("malformed complete line in the stimulus file");
            end else if (op != "flush") begin
                if ($fscanf(fd, "%d", n) != 1) abort_run($sformatf("bad count after %s", op));
            end
            repeat (n) begin
                @(posedge clock);
                clear_inputs();
                if (op == "dispatch") disp_valid <= 1'b1;
                else if (op == "credit") st_credit <= 1'b1;
                else if (op == "flush") flush <= 1'b1;
                else if (op == "complete") begin
                    // tag f draws any in-flight tag that has not completed
                    if (tag == 'hf) begin
                        pool.delete();
                        foreach (prog_q[i]) if (!done[prog_q[i]]) pool.push_back(prog_q[i]);
                        if (pool.size() == 0) abort_run("no outstanding tag to complete");
                        tag = pool[$urandom % pool.size()];
                    end
                    cmp_valid      <= 1'b1;
                    cmp_tag        <= tag_w'(tag);
                    cmp_kind       <= funit_e'(kind);
                    cmp_illegal    <= ill[0];
                    cmp_halt       <= halt[0];
                    cmp_rd_en      <= wen[0];
                    cmp_rd_idx     <= widx;
                    cmp_rd_data    <= wdata;
                    cmp_npc        <= npc;
                    cmp_result     <= res;
                    cmp_store_data <= sdata;
                end else if (op != "idle") abort_run($sformatf("unknown operation %s", op));
                @(negedge clock);
                step_model();
            end
        end
        $fclose(fd);
        // drain the window and the store queue
        while (prog_q.size() != 0 || st_q.size() != 0) begin
            @(posedge clock);
            clear_inputs();
            @(negedge clock);
            step_model();
        end
        $display(">>> PASS");
        $finish;
    end

    // budget starts once reset is released and the line count is final
    initial begin
        wait (arst_n === 1'b1);
        #(n_lines * 200 * period);
        abort_run($sformatf("timeout after %0d clock periods", n_lines * 200));
    end

endmodule

// ==== retire_sys.f ====
design/retire_pkg.sv
design/rob_tracker.sv
design/retire.sv
design/store_issue.sv
design/retire_sys.sv
dv/retire_sys_tb.sv

// ==== Bender.yml ====
package:
  name: retire_sys

sources:
  - target: rtl
    files:
      - design/retire_pkg.sv
      - design/rob_tracker.sv
      - design/retire.sv
      - design/store_issue.sv
      - design/retire_sys.sv
  - target: simulation
    files:
      - design/retire_pkg.sv
      - design/rob_tracker.sv
      - design/retire.sv
      - design/store_issue.sv
      - design/retire_sys.sv
      - dv/retire_sys_tb.sv

// ==== dv/retire_sys_testdata.txt ====
# dispatch, credit or idle with a repeat count, flush alone, or complete with hex fields
# complete tag(f picks an outstanding tag) kind illegal halt rd_en rd_idx rd_data npc result st_data
dispatch 8
complete 3 0 1 0 1 03 00000033 00001010 00000033 0
complete 1 1 1 1 1 01 00000011 00001008 00002000 0
complete 0 3 0 1 0 00 0 00001004 0 0
dispatch 1
complete 2 2 0 0 0 00 0 0000100c 00003000 000000aa
complete f 0 0 0 1 04 00000044 00001014 00000044 0
complete f 2 0 0 0 00 0 00001018 00003004 000000bb
complete f 2 0 0 0 00 0 0000101c 00003008 000000cc
complete f 2 0 0 0 00 0 00001020 0000300c 000000dd
complete f 3 0 0 0 00 0 00001024 00001100 0
idle 6
dispatch 3
complete 1 2 0 0 0 00 0 00001028 00003010 000000ee
complete 2 2 0 0 0 00 0 0000102c 00003014 000000ff
complete 3 2 0 0 0 00 0 00001030 00003018 00000011
idle 2
credit 1
idle 3
dispatch 2
complete 5 1 0 0 1 05 00000055 00001038 00004000 0
flush
dispatch 1
complete 6 0 0 0 1 06 00000066 00001040 00000066 0
credit 4
